// File: verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int XLEN      = 32;
    localparam int REG_SEL_W = 3;
    localparam int NUM_REGS  = 8;

    // unlisted opcode values execute as no-ops
    typedef enum logic [5:0] {
        OP_ADD   = 6'd1,
        OP_SUB   = 6'd2,
        OP_AND   = 6'd3,
        OP_OR    = 6'd4,
        OP_XOR   = 6'd5,
        OP_LDI   = 6'd6,
        OP_STORE = 6'd7,
        OP_CMPLT = 6'd8,
        OP_JMPF  = 6'd9,
        OP_HALT  = 6'd10
    } opcode_e;

    typedef struct packed {
        logic [15:0]          imm;
        logic                 hl;
        logic [REG_SEL_W-1:0] rd;
        logic [REG_SEL_W-1:0] rb;
        logic [REG_SEL_W-1:0] ra;
        opcode_e              op;
    } alu_instr_t;

    // JMPF reuses everything above ra as one flat target field
    typedef struct packed {
        logic [22:0]          target;
        logic [REG_SEL_W-1:0] ra;
        opcode_e              op;
    } jump_instr_t;

    typedef union packed {
        alu_instr_t  alu;
        jump_instr_t jump;
    } instr_u;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic            we;
        logic [XLEN-1:0] wdata;
    } mem_cmd_t;

    typedef struct packed {
        logic                 en;
        logic [REG_SEL_W-1:0] rd;
        logic [XLEN-1:0]      data;
        logic                 flag;
    } reg_wr_t;

endpackage

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import cpu_pkg::*;
(
    input  logic            clock,
    input  logic            rst,
    input  instr_u          instr,
    input  reg_wr_t         reg_wr,
    output logic [XLEN-1:0] rdata_a,
    output logic [XLEN-1:0] rdata_b,
    output logic            flag_a
);

    logic [XLEN-1:0]      regs [NUM_REGS];
    logic [NUM_REGS-1:0]  flags;
    logic [REG_SEL_W-1:0] sel_a;
    logic [REG_SEL_W-1:0] sel_b;

    // ra sits at the same bits in the jump view, so JMPF reads its flag here too
    assign sel_a = instr.alu.ra;
    assign sel_b = instr.alu.rb;

    assign rdata_a = regs[sel_a];
    assign rdata_b = regs[sel_b];
    assign flag_a  = flags[sel_a];

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
            // flags come up set
            flags <= '1;
        end
        else if (reg_wr.en)
        begin
            regs[reg_wr.rd]  <= reg_wr.data;
            flags[reg_wr.rd] <= reg_wr.flag;
        end
    end

    a_wr_known: assert property (@(posedge clock) disable iff (rst)
        reg_wr.en |-> !$isunknown(reg_wr))
        else $error("register write carries unknown bits");

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import cpu_pkg::*;
(
    input  instr_u          instr,
    input  logic [XLEN-1:0] rdata_a,
    input  logic [XLEN-1:0] rdata_b,
    input  logic            flag_a,
    output logic [XLEN-1:0] result,
    output logic            flag_out,
    output logic            jump_taken,
    output logic [XLEN-1:0] jump_target
);

    logic [XLEN-1:0] ldi_value;

    // rb names the destination for LDI, so rdata_b is the old value
    always_comb
    begin
        if (instr.alu.hl)
        begin
            ldi_value = {instr.alu.imm, rdata_b[15:0]};
        end
        else
        begin
            ldi_value = {rdata_b[31:16], instr.alu.imm};
        end
    end

    always_comb
    begin
        result   = '0;
        flag_out = 1'b0;
        case (instr.alu.op)
            OP_ADD:
            begin
                result   = rdata_a + rdata_b;
                flag_out = (result != '0);
            end
            OP_SUB:
            begin
                result   = rdata_a - rdata_b;
                flag_out = (result != '0);
            end
            OP_AND:
            begin
                result   = rdata_a & rdata_b;
                flag_out = (result != '0);
            end
            OP_OR:
            begin
                result   = rdata_a | rdata_b;
                flag_out = (result != '0);
            end
            OP_XOR:
            begin
                result   = rdata_a ^ rdata_b;
                flag_out = (result != '0);
            end
            OP_LDI:
            begin
                result   = ldi_value;
                flag_out = 1'b1;
            end
            OP_CMPLT:
            begin
                // unsigned compare, B passes through
                result   = rdata_b;
                flag_out = (rdata_a < rdata_b);
            end
            default:
            begin
                result   = '0;
                flag_out = 1'b0;
            end
        endcase
    end

    assign jump_taken  = (instr.jump.op == OP_JMPF) && flag_a;
    assign jump_target = {{(XLEN - $bits(instr.jump.target)){1'b0}}, instr.jump.target};

endmodule

`default_nettype wire

// File: verilog/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control
    import cpu_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
)
(
    input  logic            clock,
    input  logic            rst,
    output logic            mem_req,
    output mem_cmd_t        mem_cmd,
    input  logic            mem_ack,
    input  logic [XLEN-1:0] mem_rdata,
    output instr_u          instr,
    input  logic [XLEN-1:0] rdata_a,
    input  logic [XLEN-1:0] result,
    input  logic            flag_out,
    input  logic            jump_taken,
    input  logic [XLEN-1:0] jump_target,
    output reg_wr_t         reg_wr,
    output logic            halted
);

    // *_rel waits for the previous ack to drop, *_req holds the request until ack
    typedef enum logic [2:0] {
        S_FETCH_REL,
        S_FETCH_REQ,
        S_EXEC,
        S_STORE_REL,
        S_STORE_REQ,
        S_HALT
    } step_e;

    step_e           state;
    logic [XLEN-1:0] pc;
    instr_u          ir;
    logic            writes_reg;

    assign instr  = ir;
    assign halted = (state == S_HALT);

    assign writes_reg = ir.alu.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                          OP_LDI, OP_CMPLT};

    assign reg_wr.en   = (state == S_EXEC) && writes_reg;
    assign reg_wr.rd   = ir.alu.rd;
    assign reg_wr.data = result;
    assign reg_wr.flag = flag_out;

    always_ff @(posedge clock)
    begin
        if (state == S_FETCH_REQ && mem_ack)
        begin
            ir <= mem_rdata;
        end
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state   <= S_FETCH_REL;
            pc      <= RESET_PC;
            mem_req <= 1'b0;
            mem_cmd <= '0;
        end
        else
        begin
            case (state)
                S_FETCH_REL:
                begin
                    if (!mem_ack)
                    begin
                        mem_req       <= 1'b1;
                        mem_cmd.addr  <= pc;
                        mem_cmd.we    <= 1'b0;
                        mem_cmd.wdata <= '0;
                        state         <= S_FETCH_REQ;
                    end
                end
                S_FETCH_REQ:
                begin
                    if (mem_ack)
                    begin
                        mem_req <= 1'b0;
                        state   <= S_EXEC;
                    end
                end
                S_EXEC:
                begin
                    pc <= jump_taken ? jump_target : pc + XLEN'(1);
                    case (ir.alu.op)
                        OP_STORE: state <= S_STORE_REL;
                        OP_HALT:  state <= S_HALT;
                        default:  state <= S_FETCH_REL;
                    endcase
                end
                S_STORE_REL:
                begin
                    if (!mem_ack)
                    begin
                        mem_req       <= 1'b1;
                        mem_cmd.addr  <= {{(XLEN - 16){1'b0}}, ir.alu.imm};
                        mem_cmd.we    <= 1'b1;
                        mem_cmd.wdata <= rdata_a;
                        state         <= S_STORE_REQ;
                    end
                end
                S_STORE_REQ:
                begin
                    if (mem_ack)
                    begin
                        mem_req <= 1'b0;
                        state   <= S_FETCH_REL;
                    end
                end
                S_HALT:  state <= S_HALT;
                default: state <= S_FETCH_REL;
            endcase
        end
    end

    a_cmd_stable: assert property (@(posedge clock) disable iff (rst)
        mem_req && !mem_ack |=> $stable(mem_cmd))
        else $error("memory command changed during a request");

    a_req_after_ack: assert property (@(posedge clock) disable iff (rst)
        !mem_req && mem_ack |=> !mem_req)
        else $error("request raised while ack still high");

    // execute is the single cycle right after the fetch ack
    a_wr_in_exec: assert property (@(posedge clock) disable iff (rst)
        reg_wr.en |-> $past(state == S_FETCH_REQ && mem_ack))
        else $error("register write outside the execute step");

endmodule

`default_nettype wire

// File: verilog/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core
    import cpu_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
)
(
    input  logic            clock,
    input  logic            rst,
    output logic            mem_req,
    output mem_cmd_t        mem_cmd,
    input  logic            mem_ack,
    input  logic [XLEN-1:0] mem_rdata,
    output logic            halted
);

    instr_u          instr;
    reg_wr_t         reg_wr;
    logic [XLEN-1:0] rdata_a;
    logic [XLEN-1:0] rdata_b;
    logic            flag_a;
    logic [XLEN-1:0] result;
    logic            flag_out;
    logic            jump_taken;
    logic [XLEN-1:0] jump_target;

    cpu_control #(
        .RESET_PC(RESET_PC)
    ) i_control (
        .clock       (clock),
        .rst         (rst),
        .mem_req     (mem_req),
        .mem_cmd     (mem_cmd),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .instr       (instr),
        .rdata_a     (rdata_a),
        .result      (result),
        .flag_out    (flag_out),
        .jump_taken  (jump_taken),
        .jump_target (jump_target),
        .reg_wr      (reg_wr),
        .halted      (halted)
    );

    reg_file i_reg_file (
        .clock   (clock),
        .rst     (rst),
        .instr   (instr),
        .reg_wr  (reg_wr),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .flag_a  (flag_a)
    );

    alu i_alu (
        .instr       (instr),
        .rdata_a     (rdata_a),
        .rdata_b     (rdata_b),
        .flag_a      (flag_a),
        .result      (result),
        .flag_out    (flag_out),
        .jump_taken  (jump_taken),
        .jump_target (jump_target)
    );

endmodule

`default_nettype wire

// File: test/cpu_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_mem_model
    import cpu_pkg::*;
(
    input  logic            clock,
    input  logic            rst,
    input  logic            mem_req,
    input  mem_cmd_t        mem_cmd,
    output logic            mem_ack,
    output logic [XLEN-1:0] mem_rdata
);

    // preloaded from the testbench before reset is released
    logic [XLEN-1:0] mem [256];
    integer          seed;
    int              wait_cycles;

    initial
    begin
        seed      = 32'h27eb944d;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever
        begin
            @(posedge clock);
            if (!rst && mem_req && !mem_ack)
            begin
                wait_cycles = {$random(seed)} % 4;
                repeat (wait_cycles) @(posedge clock);
                #1;
                if (mem_cmd.we)
                begin
                    mem[mem_cmd.addr[7:0]] = mem_cmd.wdata;
                end
                else
                begin
                    mem_rdata = mem[mem_cmd.addr[7:0]];
                end
                mem_ack = 1'b1;
                // hold ack until the request has gone away
                @(posedge clock);
                while (mem_req) @(posedge clock);
                #1;
                mem_ack = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: test/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb
    import cpu_pkg::*;
;

    logic            clock = 1'b0;
    logic            rst;
    logic            mem_req;
    mem_cmd_t        mem_cmd;
    logic            mem_ack;
    logic [XLEN-1:0] mem_rdata;
    logic            halted;

    logic [31:0] program_mem [256];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          exp_count;
    int          errors = 0;
    int          store_idx = 0;
    int          fetch_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    bit          first_seen = 1'b0;
    bit          late_req_seen = 1'b0;

    always #4 clock = ~clock;

    cpu_core #(
        .RESET_PC(32'h0)
    ) i_dut (
        .clock     (clock),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    cpu_mem_model i_mem (
        .clock     (clock),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual)
        begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] encode_alu(opcode_e op, int rd, int ra, int rb, bit hl,
                                               logic [15:0] imm);
        return {imm, hl, 3'(rd), 3'(rb), 3'(ra), op};
    endfunction

    function automatic logic [31:0] encode_jump(int ra, int target);
        return {23'(target), 3'(ra), OP_JMPF};
    endfunction

    task automatic load_program();
        for (int i = 0; i < 256; i++)
        begin
            program_mem[i] = {8'hee, 16'h0, 8'(i)} ^ {8'(i), 24'h0};
        end
        // LDI names the destination in rb as well
        program_mem[0]  = encode_alu(OP_LDI, 1, 0, 1, 1'b1, 16'h1234);
        program_mem[1]  = encode_alu(OP_LDI, 1, 0, 1, 1'b0, 16'h5678);
        program_mem[2]  = encode_alu(OP_LDI, 2, 0, 2, 1'b1, 16'h0f0f);
        program_mem[3]  = encode_alu(OP_LDI, 2, 0, 2, 1'b0, 16'ha5a5);
        program_mem[4]  = encode_alu(OP_STORE, 0, 1, 0, 1'b0, 16'h0080);
        program_mem[5]  = encode_alu(OP_STORE, 0, 2, 0, 1'b0, 16'h0081);
        program_mem[6]  = encode_alu(OP_ADD, 3, 1, 2, 1'b0, 16'h0);
        program_mem[7]  = encode_alu(OP_STORE, 0, 3, 0, 1'b0, 16'h0082);
        program_mem[8]  = encode_alu(OP_SUB, 4, 1, 2, 1'b0, 16'h0);
        program_mem[9]  = encode_alu(OP_STORE, 0, 4, 0, 1'b0, 16'h0083);
        program_mem[10] = encode_alu(OP_AND, 5, 1, 2, 1'b0, 16'h0);
        program_mem[11] = encode_alu(OP_STORE, 0, 5, 0, 1'b0, 16'h0084);
        program_mem[12] = encode_alu(OP_OR, 6, 1, 2, 1'b0, 16'h0);
        program_mem[13] = encode_alu(OP_STORE, 0, 6, 0, 1'b0, 16'h0085);
        program_mem[14] = encode_alu(OP_XOR, 7, 1, 2, 1'b0, 16'h0);
        program_mem[15] = encode_alu(OP_STORE, 0, 7, 0, 1'b0, 16'h0086);
        // r0 still has its reset flag, so this jump is taken
        program_mem[16] = encode_jump(0, 18);
        program_mem[17] = encode_alu(OP_STORE, 0, 1, 0, 1'b0, 16'h0087);
        program_mem[18] = encode_alu(OP_CMPLT, 4, 1, 2, 1'b0, 16'h0);
        program_mem[19] = encode_jump(4, 22);
        program_mem[20] = encode_alu(OP_STORE, 0, 4, 0, 1'b0, 16'h0088);
        program_mem[21] = encode_alu(OP_CMPLT, 5, 2, 1, 1'b0, 16'h0);
        program_mem[22] = encode_jump(5, 24);
        program_mem[23] = encode_alu(OP_STORE, 0, 5, 0, 1'b0, 16'h0089);
        program_mem[24] = encode_alu(OP_STORE, 0, 5, 0, 1'b0, 16'h008a);
        program_mem[25] = encode_alu(OP_HALT, 0, 0, 0, 1'b0, 16'h0);
    endtask

    // walks the program from the reset state and returns the instruction count
    function automatic int ref_run();
        logic [31:0] m [256];
        logic [31:0] r [8];
        logic [7:0]  f;
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [2:0]  rd;
        int          count;
        bit          done;
        for (int i = 0; i < 256; i++)
        begin
            m[i] = program_mem[i];
        end
        for (int i = 0; i < 8; i++)
        begin
            r[i] = '0;
        end
        f = '1;
        pc = '0;
        count = 0;
        done = 1'b0;
        exp_addr.delete();
        exp_data.delete();
        while (!done && count < 1000)
        begin
            w = m[pc[7:0]];
            count++;
            a = r[w[8:6]];
            b = r[w[11:9]];
            rd = w[14:12];
            pc = pc + 1;
            case (w[5:0])
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:
                begin
                    case (w[5:0])
                        OP_ADD:  res = a + b;
                        OP_SUB:  res = a - b;
                        OP_AND:  res = a & b;
                        OP_OR:   res = a | b;
                        default: res = a ^ b;
                    endcase
                    r[rd] = res;
                    f[rd] = (res != 0);
                end
                OP_LDI:
                begin
                    r[rd] = w[15] ? {w[31:16], r[rd][15:0]} : {r[rd][31:16], w[31:16]};
                    f[rd] = 1'b1;
                end
                OP_CMPLT:
                begin
                    r[rd] = b;
                    f[rd] = (a < b);
                end
                OP_JMPF:
                begin
                    if (f[w[8:6]])
                    begin
                        pc = {9'h0, w[31:9]};
                    end
                end
                OP_STORE:
                begin
                    exp_addr.push_back({16'h0, w[31:16]});
                    exp_data.push_back(a);
                    m[w[23:16]] = a;
                end
                OP_HALT: done = 1'b1;
                default: ;
            endcase
        end
        return count;
    endfunction

    // one posedge per handshake has both req and ack high
    always @(posedge clock)
    begin
        if (!rst && mem_req && !first_seen)
        begin
            first_seen = 1'b1;
            check_value("first fetch address", 32'h0, mem_cmd.addr);
            check_value("first fetch write enable", 32'h0, 32'(mem_cmd.we));
            check_value("halted at first fetch", 32'h0, 32'(halted));
        end
        if (!rst && mem_req && mem_ack)
        begin
            if (!mem_cmd.we)
            begin
                fetch_count++;
            end
            else if (store_idx < exp_addr.size())
            begin
                check_value($sformatf("store %0d address", store_idx), exp_addr[store_idx],
                            mem_cmd.addr);
                check_value($sformatf("store %0d data", store_idx), exp_data[store_idx],
                            mem_cmd.wdata);
                store_idx++;
            end
            else
            begin
                errors++;
                store_idx++;
                $display("unexpected extra store to address %h", mem_cmd.addr);
            end
        end
        if (!rst && halted && mem_req && !late_req_seen)
        begin
            late_req_seen = 1'b1;
            errors++;
            $display("memory request issued after the core halted");
        end
    end

    always @(posedge clock)
    begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit && !halted)
        begin
            errors++;
            $display("timeout after %0d cycles, the core never halted", cycle_count);
            $display("errors %0d, stores %0d, fetches %0d", errors, store_idx, fetch_count);
            $display("tests failed");
            $finish;
        end
    end

    initial
    begin
        rst = 1'b1;
        load_program();
        for (int i = 0; i < 256; i++)
        begin
            i_mem.mem[i] = program_mem[i];
        end
        exp_count = ref_run();
        cycle_limit = 40 * exp_count + 100;
        repeat (8) @(posedge clock);
        #1;
        rst = 1'b0;
        wait (halted);
        repeat (10) @(posedge clock);
        check_value("halted held", 32'h1, 32'(halted));
        check_value("fetch count", 32'(exp_count), 32'(fetch_count));
        check_value("store count", 32'(exp_addr.size()), 32'(store_idx));
        $display("errors %0d, stores %0d, fetches %0d", errors, store_idx, fetch_count);
        if (errors == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cpu_core.f
verilog/cpu_pkg.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/cpu_control.sv
verilog/cpu_core.sv
test/cpu_mem_model.sv
test/cpu_tb.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - files:
      - verilog/cpu_pkg.sv
      - verilog/reg_file.sv
      - verilog/alu.sv
      - verilog/cpu_control.sv
      - verilog/cpu_core.sv
  - target: test
    files:
      - test/cpu_mem_model.sv
      - test/cpu_tb.sv
